/* logic/switch_cfg.svh */
// Switch configuration shared by RTL and testbench
// SW_FWD_DELAY below 8 leaves no time for the lookup before a frame exits
`ifndef SWITCH_CFG_SVH
`define SWITCH_CFG_SVH

// Number of switch ports, one bit each in an egress mask
`define SW_NUM_PORTS 4

// Learning table index width, 2**N entries
`define SW_TABLE_ADDR_LEN 3

// Ingress to egress latency in cycles
`define SW_FWD_DELAY 8

// Shortest frame in bytes, addresses plus type field
`define SW_MIN_FRAME 14

`endif

/* logic/switch_pkg.sv */
// Switch types; port widths follow SW_NUM_PORTS from the config header
`default_nettype none

`include "switch_cfg.svh"

package switch_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [$clog2(`SW_NUM_PORTS)-1:0] port_id_t;
	typedef logic [`SW_NUM_PORTS-1:0] port_mask_t; // One bit per egress port
	typedef logic [15:0] frame_count_t; // Wraps silently
	typedef logic [7:0] reg_addr_t;

	// Decoder position within a frame
	typedef enum logic [1:0] {
		DEC_DST,
		DEC_SRC,
		DEC_BODY
	} dec_state_t;

endpackage

`default_nettype wire

/* logic/frame_decoder.sv */
// Expects contiguous frames of at least 12 bytes; rx_port must hold for the whole frame
`timescale 1ns/100ps
`default_nettype none

module frame_decoder
	import switch_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rx_valid,
	input wire byte_t rx_data,
	input wire rx_last,
	input wire port_id_t rx_port,
	output logic lookup_valid,
	output mac_addr_t dst_mac,
	output port_id_t lookup_port,
	output logic learn_valid,
	output mac_addr_t src_mac,
	output port_id_t learn_port
);
	localparam int MAC_BYTES = $bits(mac_addr_t) / 8;

	dec_state_t state;
	logic [2:0] byte_cnt; // Position inside the current address field
	logic field_done;

	// Last byte of an address field is on the bus
	assign field_done = rx_valid && (byte_cnt == 3'(MAC_BYTES - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= DEC_DST;
			byte_cnt <= '0;
			lookup_valid <= 1'b0;
			learn_valid <= 1'b0;
		end
		else
		begin
			lookup_valid <= 1'b0;
			learn_valid <= 1'b0;
			if (rx_valid)
			begin
				case (state)
					DEC_DST:
					begin
						byte_cnt <= field_done ? 3'd0 : byte_cnt + 3'd1;
						if (field_done)
						begin
							state <= DEC_SRC;
							lookup_valid <= 1'b1; // Destination complete
						end
					end
					DEC_SRC:
					begin
						byte_cnt <= field_done ? 3'd0 : byte_cnt + 3'd1;
						if (field_done)
						begin
							state <= DEC_BODY;
							learn_valid <= 1'b1;
						end
					end
					default: byte_cnt <= '0; // Body bytes are not counted
				endcase
				if (rx_last)
				begin
					state <= DEC_DST;
					byte_cnt <= '0;
				end
			end
		end
	end

	// First byte lands in the top, so the address reads in wire order
	always_ff @(posedge clk)
	begin
		if (rx_valid && state == DEC_DST)
			dst_mac <= {dst_mac[$bits(mac_addr_t)-9:0], rx_data};
		if (rx_valid && state == DEC_SRC)
			src_mac <= {src_mac[$bits(mac_addr_t)-9:0], rx_data};
		if (field_done && state == DEC_DST)
			lookup_port <= rx_port;
		if (field_done && state == DEC_SRC)
			learn_port <= rx_port;
	end

endmodule

`default_nettype wire

/* logic/mac_table.sv */
// Direct mapped, no aging; a colliding source simply evicts the old entry
// TABLE_ADDR_LEN must not exceed 8, the index comes from the last address byte
`timescale 1ns/100ps
`default_nettype none

`include "switch_cfg.svh"

module mac_table
	import switch_pkg::*;
#(
	parameter int TABLE_ADDR_LEN = `SW_TABLE_ADDR_LEN
)(
	input wire clk,
	input wire reset,
	input wire lookup_valid,
	input wire mac_addr_t dst_mac,
	input wire port_id_t lookup_port,
	input wire learn_valid,
	input wire mac_addr_t src_mac,
	input wire port_id_t learn_port,
	output logic mask_valid,
	output port_mask_t egress_mask
);
	localparam int TABLE_SIZE = 1 << TABLE_ADDR_LEN;

	logic [TABLE_SIZE-1:0] entry_valid;
	mac_addr_t entry_mac [TABLE_SIZE];
	port_id_t entry_port [TABLE_SIZE];

	logic [TABLE_ADDR_LEN-1:0] lookup_idx;
	logic [TABLE_ADDR_LEN-1:0] learn_idx;
	logic is_bcast;
	logic hit;
	port_mask_t ingress_bit;
	port_mask_t base_mask;

	assign lookup_idx = dst_mac[TABLE_ADDR_LEN-1:0];
	assign learn_idx = src_mac[TABLE_ADDR_LEN-1:0];
	assign is_bcast = &dst_mac;
	assign hit = entry_valid[lookup_idx] && (entry_mac[lookup_idx] == dst_mac);
	assign ingress_bit = port_mask_t'(1) << lookup_port;

	// Broadcast and misses flood, hits go to the stored port
	always_comb
	begin
		if (hit && !is_bcast)
			base_mask = port_mask_t'(1) << entry_port[lookup_idx];
		else
			base_mask = '1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			mask_valid <= 1'b0;
		end
		else
		begin
			mask_valid <= lookup_valid;
			if (learn_valid)
				entry_valid[learn_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (learn_valid)
		begin
			entry_mac[learn_idx] <= src_mac; // Overwrites whatever was there
			entry_port[learn_idx] <= learn_port;
		end
		// Never send a frame back out of its own port
		if (lookup_valid)
			egress_mask <= base_mask & ~ingress_bit;
	end

endmodule

`default_nettype wire

/* logic/frame_forwarder.sv */
// Fixed latency replay; the mask must be queued before the first byte leaves the delay line
`timescale 1ns/100ps
`default_nettype none

`include "switch_cfg.svh"

module frame_forwarder
	import switch_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rx_valid,
	input wire byte_t rx_data,
	input wire rx_last,
	input wire mask_valid,
	input wire port_mask_t egress_mask,
	output port_mask_t tx_valid,
	output byte_t tx_data,
	output logic tx_last
);
	localparam int DELAY = `SW_FWD_DELAY;

	byte_t dly_data [DELAY];
	logic [DELAY-1:0] dly_valid;
	logic [DELAY-1:0] dly_last;
	logic [DELAY-1:0] dly_first;
	logic in_frame; // Ingress is past the first byte
	port_mask_t mask_q [2];
	logic wr_ptr;
	logic rd_ptr;
	port_mask_t held_mask; // Mask of the frame now leaving
	logic out_valid;
	logic out_first;
	port_mask_t cur_mask;

	assign out_valid = dly_valid[DELAY-1];
	assign out_first = out_valid && dly_first[DELAY-1];
	assign cur_mask = out_first ? mask_q[rd_ptr] : held_mask;
	assign tx_valid = out_valid ? cur_mask : '0;
	assign tx_data = dly_data[DELAY-1];
	assign tx_last = dly_last[DELAY-1] && (cur_mask != '0); // Dropped frames end silently

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dly_valid <= '0;
			dly_last <= '0;
			dly_first <= '0;
			in_frame <= 1'b0;
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			held_mask <= '0;
		end
		else
		begin
			dly_valid <= {dly_valid[DELAY-2:0], rx_valid};
			dly_last <= {dly_last[DELAY-2:0], rx_valid && rx_last};
			dly_first <= {dly_first[DELAY-2:0], rx_valid && !in_frame};
			if (rx_valid)
				in_frame <= !rx_last;
			if (mask_valid)
				wr_ptr <= !wr_ptr;
			if (out_first)
			begin
				rd_ptr <= !rd_ptr; // Pop
				held_mask <= mask_q[rd_ptr];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		dly_data[0] <= rx_data;
		for (int i = 1; i < DELAY; i++)
			dly_data[i] <= dly_data[i-1];
		if (mask_valid)
			mask_q[wr_ptr] <= egress_mask;
	end

endmodule

`default_nettype wire

/* logic/port_counters.sv */
// Register map: port*4 is rx frames, port*4+1 is tx frames, all else reads zero
// Counters wrap; reads have no side effects
`timescale 1ns/100ps
`default_nettype none

`include "switch_cfg.svh"

module port_counters
	import switch_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rx_valid,
	input wire rx_last,
	input wire port_id_t rx_port,
	input wire port_mask_t tx_valid,
	input wire tx_last,
	input wire reg_valid,
	input wire reg_addr_t reg_addr,
	output logic reg_ready,
	output frame_count_t reg_rdata
);
	localparam int NUM_PORTS = `SW_NUM_PORTS;

	frame_count_t rx_cnt [NUM_PORTS];
	frame_count_t tx_cnt [NUM_PORTS];
	reg_addr_t reg_word; // Address with the counter select dropped
	port_id_t rd_port;
	logic addr_ok;

	assign reg_word = reg_addr >> 2;
	assign rd_port = port_id_t'(reg_word);
	assign addr_ok = (reg_word < reg_addr_t'(NUM_PORTS)) && !reg_addr[1];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				rx_cnt[p] <= '0;
				tx_cnt[p] <= '0;
			end
			reg_ready <= 1'b0;
		end
		else
		begin
			reg_ready <= reg_valid;
			if (rx_valid && rx_last)
				rx_cnt[rx_port] <= rx_cnt[rx_port] + frame_count_t'(1);
			// One egress frame per port that carried it
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				if (tx_last && tx_valid[p])
					tx_cnt[p] <= tx_cnt[p] + frame_count_t'(1);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reg_valid)
		begin
			if (!addr_ok)
				reg_rdata <= '0;
			else if (reg_addr[0])
				reg_rdata <= tx_cnt[rd_port];
			else
				reg_rdata <= rx_cnt[rd_port];
		end
	end

endmodule

`default_nettype wire

/* logic/l2_switch_top.sv */
// Single clock switch core; no back-pressure on ingress or on the register bus
`timescale 1ns/100ps
`default_nettype none

module l2_switch_top
	import switch_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rx_valid,
	input wire byte_t rx_data,
	input wire rx_last,
	input wire port_id_t rx_port,
	input wire reg_valid,
	input wire reg_addr_t reg_addr,
	output port_mask_t tx_valid,
	output byte_t tx_data,
	output logic tx_last,
	output logic reg_ready,
	output frame_count_t reg_rdata
);
	logic lookup_valid;
	mac_addr_t dst_mac;
	port_id_t lookup_port;
	logic learn_valid;
	mac_addr_t src_mac;
	port_id_t learn_port;
	logic mask_valid;
	port_mask_t egress_mask;

	frame_decoder i_frame_decoder (
		.clk(clk),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_last(rx_last),
		.rx_port(rx_port),
		.lookup_valid(lookup_valid),
		.dst_mac(dst_mac),
		.lookup_port(lookup_port),
		.learn_valid(learn_valid),
		.src_mac(src_mac),
		.learn_port(learn_port)
	);

	mac_table i_mac_table (
		.clk(clk),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.dst_mac(dst_mac),
		.lookup_port(lookup_port),
		.learn_valid(learn_valid),
		.src_mac(src_mac),
		.learn_port(learn_port),
		.mask_valid(mask_valid),
		.egress_mask(egress_mask)
	);

	frame_forwarder i_frame_forwarder (
		.clk(clk),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_last(rx_last),
		.mask_valid(mask_valid),
		.egress_mask(egress_mask),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_last(tx_last)
	);

	// Counts the egress side as seen on the common bus
	port_counters i_port_counters (
		.clk(clk),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_last(rx_last),
		.rx_port(rx_port),
		.tx_valid(tx_valid),
		.tx_last(tx_last),
		.reg_valid(reg_valid),
		.reg_addr(reg_addr),
		.reg_ready(reg_ready),
		.reg_rdata(reg_rdata)
	);

endmodule

`default_nettype wire

/* testbench/l2_switch_checker.sv */
// Bound to l2_switch_top; assumes rx_port holds for the whole frame
`timescale 1ns/100ps
`default_nettype none

`include "switch_cfg.svh"

module l2_switch_checker
	import switch_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rx_valid,
	input wire port_id_t rx_port,
	input wire port_mask_t tx_valid,
	input wire tx_last,
	input wire reg_valid,
	input wire reg_ready
);
	localparam int DELAY = `SW_FWD_DELAY;

	int fail_count = 0; // Failed assertions so far

	// Reply exactly one cycle after each request, never otherwise
	reg_reply: assert property (@(posedge clk) disable iff (reset)
		reg_ready == $past(reg_valid))
	else
	begin
		fail_count++;
		$error("reg_ready does not follow reg_valid by one cycle");
	end

	tx_last_valid: assert property (@(posedge clk) disable iff (reset)
		tx_last |-> (tx_valid != '0))
	else
	begin
		fail_count++;
		$error("tx_last without tx_valid");
	end

	// Port that sent the frame DELAY cycles ago
	no_reflect: assert property (@(posedge clk) disable iff (reset)
		(tx_valid != '0) |-> ((tx_valid & (port_mask_t'(1) << $past(rx_port, DELAY))) == '0))
	else
	begin
		fail_count++;
		$error("frame sent back out of its ingress port");
	end

	quiet_egress: assert property (@(posedge clk) disable iff (reset)
		(tx_valid != '0) |-> $past(rx_valid, DELAY))
	else
	begin
		fail_count++;
		$error("tx_valid without an ingress byte DELAY cycles earlier");
	end

endmodule

bind l2_switch_top l2_switch_checker i_l2_switch_checker (
	.clk(clk),
	.reset(reset),
	.rx_valid(rx_valid),
	.rx_port(rx_port),
	.tx_valid(tx_valid),
	.tx_last(tx_last),
	.reg_valid(reg_valid),
	.reg_ready(reg_ready)
);

`default_nettype wire

/* testbench/l2_switch_tb.sv */
// Frames are sent one at a time on a single ingress port; expected egress comes from a table model
// Body bytes are random with a fixed seed, so every run repeats
`timescale 1ns/100ps
`default_nettype none

`include "switch_cfg.svh"

module l2_switch_tb
	import switch_pkg::*;
();
	localparam int DELAY = `SW_FWD_DELAY;
	localparam int NUM_PORTS = `SW_NUM_PORTS;
	localparam int TABLE_SIZE = 1 << `SW_TABLE_ADDR_LEN;
	localparam int TIMEOUT_CYCLES = 2000; // About 20 frames of up to 40 bytes, drains and reads
	localparam mac_addr_t BCAST = '1;
	localparam mac_addr_t MAC_U = 48'h02_00_00_00_77_03;
	localparam mac_addr_t MAC_S = 48'h02_00_00_00_01_01;
	localparam mac_addr_t MAC_V = 48'h02_00_00_00_66_06;
	localparam mac_addr_t MAC_A = 48'h02_00_00_00_0a_05;
	localparam mac_addr_t MAC_B = 48'h02_00_00_00_0b_05; // Same table index as MAC_A
	localparam mac_addr_t MAC_C = 48'h02_00_00_00_0c_02;
	localparam mac_addr_t MAC_D = 48'h02_00_00_00_0d_04;

	logic clk;
	logic reset;
	logic rx_valid;
	byte_t rx_data;
	logic rx_last;
	port_id_t rx_port;
	logic reg_valid;
	reg_addr_t reg_addr;
	port_mask_t tx_valid;
	byte_t tx_data;
	logic tx_last;
	logic reg_ready;
	frame_count_t reg_rdata;

	integer seed = 42362;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int errors_before = 0;
	int cycle_count = 0;
	logic checking = 1'b0;
	port_mask_t cur_mask = '0; // Predicted mask of the frame on ingress

	// Reference table and counters
	logic model_valid [TABLE_SIZE] = '{default: 1'b0};
	mac_addr_t model_mac [TABLE_SIZE] = '{default: '0};
	port_id_t model_port [TABLE_SIZE] = '{default: '0};
	frame_count_t model_rx [NUM_PORTS] = '{default: '0};
	frame_count_t model_tx [NUM_PORTS] = '{default: '0};

	// Ingress history, oldest entry at the top index
	logic [DELAY-1:0] hist_valid = '0;
	logic [DELAY-1:0] hist_last = '0;
	byte_t hist_data [DELAY];
	port_mask_t hist_mask [DELAY];
	port_mask_t exp_valid;
	logic exp_last;

	l2_switch_top i_l2_switch_top (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Broadcast and misses flood, hits go to the stored port, never back to ingress
	function automatic port_mask_t predict_mask(port_id_t port, mac_addr_t dst);
		int idx;
		port_mask_t mask;
		idx = int'(dst[`SW_TABLE_ADDR_LEN-1:0]);
		if (dst != BCAST && model_valid[idx] && model_mac[idx] == dst)
			mask = port_mask_t'(1) << model_port[idx];
		else
			mask = '1;
		return mask & ~(port_mask_t'(1) << port);
	endfunction

	task automatic report_mismatch(string name, logic [15:0] got, logic [15:0] expected);
		$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		error_count++;
	endtask

	task automatic finish_test(string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
		errors_before = error_count;
	endtask

	// Egress must repeat ingress exactly DELAY cycles later
	always @(negedge clk)
	begin
		if (checking)
		begin
			exp_valid = hist_valid[DELAY-1] ? hist_mask[DELAY-1] : '0;
			exp_last = hist_last[DELAY-1] && (exp_valid != '0);
			check_count++;
			assert (tx_valid == exp_valid)
			else report_mismatch("tx_valid", 16'(tx_valid), 16'(exp_valid));
			assert (tx_last == exp_last)
			else report_mismatch("tx_last", 16'(tx_last), 16'(exp_last));
			if (exp_valid != '0)
			begin
				assert (tx_data == hist_data[DELAY-1])
				else report_mismatch("tx_data", 16'(tx_data), 16'(hist_data[DELAY-1]));
			end
			if (exp_last)
			begin
				for (int p = 0; p < NUM_PORTS; p++)
					model_tx[p] = model_tx[p] + frame_count_t'(exp_valid[p]);
			end
		end
		for (int i = DELAY - 1; i > 0; i--)
		begin
			hist_data[i] = hist_data[i-1];
			hist_mask[i] = hist_mask[i-1];
		end
		hist_data[0] = rx_data;
		hist_mask[0] = cur_mask;
		hist_valid = {hist_valid[DELAY-2:0], rx_valid};
		hist_last = {hist_last[DELAY-2:0], rx_valid && rx_last};
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Header first, then random body; model learns the source once the mask is known
	task automatic send_frame(port_id_t port, mac_addr_t dst, mac_addr_t src, int len);
		int idx;
		byte_t data;
		port_mask_t mask;
		mask = predict_mask(port, dst);
		idx = int'(src[`SW_TABLE_ADDR_LEN-1:0]);
		model_valid[idx] = 1'b1;
		model_mac[idx] = src;
		model_port[idx] = port;
		model_rx[port] = model_rx[port] + frame_count_t'(1);
		for (int i = 0; i < len; i++)
		begin
			if (i < 6)
				data = dst[47 - 8 * i -: 8];
			else if (i < 12)
				data = src[47 - 8 * (i - 6) -: 8];
			else
				data = byte_t'($random(seed));
			@(posedge clk);
			#1;
			cur_mask = mask;
			rx_valid = 1'b1;
			rx_data = data;
			rx_last = (i == len - 1);
			rx_port = port;
		end
	endtask

	task automatic wait_egress_idle();
		@(posedge clk);
		#1;
		rx_valid = 1'b0;
		rx_last = 1'b0;
		rx_data = '0;
		do
			@(posedge clk);
		while (hist_valid != '0);
	endtask

	// Reply is due exactly one cycle after the request
	task automatic read_reg(reg_addr_t addr, frame_count_t expected);
		@(posedge clk);
		#1;
		reg_valid = 1'b1;
		reg_addr = addr;
		@(posedge clk);
		#1;
		reg_valid = 1'b0;
		@(negedge clk);
		if (!reg_ready)
		begin
			$display("Register read at address %h got no reply one cycle after the request",
				addr);
			error_count++;
		end
		else
		begin
			check_count++;
			assert (reg_rdata == expected)
			else report_mismatch("reg_rdata", reg_rdata, expected);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		rx_valid = 1'b0;
		rx_data = '0;
		rx_last = 1'b0;
		rx_port = '0;
		reg_valid = 1'b0;
		reg_addr = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		checking = 1'b1;

		send_frame(2'd1, MAC_U, MAC_S, 20);
		wait_egress_idle();
		finish_test("unknown unicast floods");

		send_frame(2'd2, MAC_V, MAC_A, 16);
		send_frame(2'd0, MAC_A, MAC_C, 24); // Back to back
		wait_egress_idle();
		finish_test("learned address goes to one port");

		send_frame(2'd3, BCAST, MAC_D, 30);
		send_frame(2'd2, MAC_A, MAC_A, 14); // Learned on its own port
		wait_egress_idle();
		finish_test("broadcast floods, own port drops");

		send_frame(2'd1, MAC_C, MAC_B, 18);
		send_frame(2'd0, MAC_A, MAC_C, 40);
		wait_egress_idle();
		finish_test("colliding source evicts entry");

		for (int p = 0; p < NUM_PORTS; p++)
		begin
			read_reg(reg_addr_t'(4 * p), model_rx[p]);
			read_reg(reg_addr_t'(4 * p + 1), model_tx[p]);
		end
		read_reg(8'h02, '0);
		read_reg(8'h10, '0); // Past the last port
		finish_test("counter reads");

		// Bound assertion failures count as errors too
		error_count = error_count + i_l2_switch_top.i_l2_switch_checker.fail_count;
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/switch_pkg.sv
logic/frame_decoder.sv
logic/mac_table.sv
logic/frame_forwarder.sv
logic/port_counters.sv
logic/l2_switch_top.sv
testbench/l2_switch_checker.sv
testbench/l2_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run; exits 1 when the log holds the failure line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module l2_switch_tb -o l2_switch_sim > sim.log 2>&1 \
	&& ./obj_dir/l2_switch_sim >> sim.log 2>&1 \
	|| echo "SIMULATION FAILED" >> sim.log
cat sim.log
if grep -q "SIMULATION FAILED" sim.log
then
	exit 1
fi
exit 0
